//--- mini_la_core.f
+incdir+include
design/mini_la_pkg.sv
design/regfile.sv
design/if_stage.sv
design/id_stage.sv
design/exe_stage.sv
design/wb_stage.sv
design/mini_la_core.sv
testbench/trace_checker.sv
testbench/tb_mini_la_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mini_la_core
FILELIST  ?= mini_la_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_mini_la_core.sv
`timescale 1ns/1ps
`include "mini_la_defines.svh"

module tb_mini_la_core;

    localparam int                 PROG_WORDS = `MINI_LA_PROG_WORDS;
    localparam int                 LABEL      = 26;  // ertn target, start of random block
    localparam logic [16:0]        OP_ADD     = 17'h00020;
    localparam logic [16:0]        OP_SUB     = 17'h00022;
    localparam logic [16:0]        OP_AND     = 17'h00029;
    localparam logic [16:0]        OP_OR      = 17'h0002a;
    localparam logic [5:0]         OP_BEQ     = 6'h16;
    localparam logic [5:0]         OP_BNE     = 6'h17;
    localparam mini_la_pkg::word_t ERTN       = 32'h06483800;

    logic                clk;
    logic                resetn;
    logic                inst_sram_en;
    mini_la_pkg::word_t  inst_sram_addr;
    mini_la_pkg::word_t  inst_sram_rdata = 32'd0;
    mini_la_pkg::word_t  sram_addr_q = `MINI_LA_TEXT_BASE;
    mini_la_pkg::trace_t trace;
    mini_la_pkg::word_t  prog [PROG_WORDS];
    logic                done;
    int                  errors;
    int                  exp_total;
    int                  cycles = 0;
    int                  timeouts = 0;
    integer              seed;

    mini_la_core UUT (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .trace           (trace)
    );

    trace_checker u_trace_checker (
        .clk       (clk),
        .resetn    (resetn),
        .trace     (trace),
        .prog      (prog),
        .done      (done),
        .errors    (errors),
        .exp_total (exp_total)
    );

    function automatic mini_la_pkg::word_t enc_3r(input logic [16:0] op,
            input mini_la_pkg::reg_idx_t rd, input mini_la_pkg::reg_idx_t rj,
            input mini_la_pkg::reg_idx_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic mini_la_pkg::word_t enc_addi(input mini_la_pkg::reg_idx_t rd,
            input mini_la_pkg::reg_idx_t rj, input logic [11:0] imm);
        return {10'h00a, imm, rj, rd};
    endfunction

    function automatic mini_la_pkg::word_t enc_lu12i(input mini_la_pkg::reg_idx_t rd,
            input logic [19:0] imm);
        return {7'h0a, imm, rd};
    endfunction

    // offsets are in words
    function automatic mini_la_pkg::word_t enc_branch(input logic [5:0] op,
            input mini_la_pkg::reg_idx_t rj, input mini_la_pkg::reg_idx_t rd,
            input logic [15:0] offs);
        return {op, offs, rj, rd};
    endfunction

    function automatic mini_la_pkg::word_t enc_b(input logic [25:0] offs);
        return {6'h14, offs[15:0], offs[25:16]};
    endfunction

    function automatic mini_la_pkg::word_t enc_csrwr(input mini_la_pkg::reg_idx_t rd);
        return {8'h04, `MINI_LA_ERA_CSR, 5'd1, rd};
    endfunction

    task automatic build_program();
        mini_la_pkg::word_t r;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = enc_addi(5'd10, 5'd0, 12'(i));  // poison, must never retire
        end
        prog[0]  = enc_lu12i(5'd1, 20'h12345);
        prog[1]  = enc_addi(5'd1, 5'd1, 12'h678);
        prog[2]  = enc_addi(5'd2, 5'd0, 12'd5);
        prog[3]  = enc_addi(5'd3, 5'd0, 12'd5);
        prog[4]  = enc_branch(OP_BEQ, 5'd2, 5'd3, 16'd2);  // taken over 5
        prog[6]  = enc_branch(OP_BNE, 5'd2, 5'd3, 16'd2);  // falls through
        prog[7]  = enc_addi(5'd4, 5'd0, 12'hfff);
        prog[8]  = enc_branch(OP_BNE, 5'd2, 5'd4, 16'd2);  // taken over 9
        prog[10] = enc_branch(OP_BEQ, 5'd1, 5'd2, 16'd2);  // not taken
        prog[11] = enc_b(26'd2);
        // dependent chain, each reads the previous result
        prog[13] = enc_3r(OP_ADD, 5'd5, 5'd1, 5'd2);
        prog[14] = enc_3r(OP_ADD, 5'd6, 5'd5, 5'd5);
        prog[15] = enc_3r(OP_SUB, 5'd7, 5'd6, 5'd1);
        prog[16] = enc_3r(OP_OR, 5'd8, 5'd7, 5'd3);
        prog[17] = enc_3r(OP_AND, 5'd9, 5'd8, 5'd1);
        prog[18] = enc_lu12i(5'd12, 20'h1c000);
        prog[19] = enc_addi(5'd12, 5'd12, 12'(LABEL * 4));
        prog[20] = enc_csrwr(5'd12);
        prog[21] = ERTN;  // 22..25 left as poison
        for (int i = LABEL; i < PROG_WORDS - 1; i++) begin
            r = $random(seed);
            case (r[2:0])
                3'd0:    prog[i] = enc_3r(OP_ADD, {1'b0, r[7:4]}, {1'b0, r[11:8]}, {1'b0, r[15:12]});
                3'd1:    prog[i] = enc_3r(OP_SUB, {1'b0, r[7:4]}, {1'b0, r[11:8]}, {1'b0, r[15:12]});
                3'd2:    prog[i] = enc_3r(OP_AND, {1'b0, r[7:4]}, {1'b0, r[11:8]}, {1'b0, r[15:12]});
                3'd3:    prog[i] = enc_3r(OP_OR, {1'b0, r[7:4]}, {1'b0, r[11:8]}, {1'b0, r[15:12]});
                3'd4:    prog[i] = enc_lu12i({1'b0, r[7:4]}, r[31:12]);
                default: prog[i] = enc_addi({1'b0, r[7:4]}, {1'b0, r[11:8]}, r[27:16]);
            endcase
        end
        prog[PROG_WORDS - 1] = enc_b(26'd0);  // self-loop
    endtask

    // outside the image the word is a function of the full address
    function automatic mini_la_pkg::word_t sram_word(input mini_la_pkg::word_t addr);
        mini_la_pkg::word_t offs;
        offs = addr - `MINI_LA_TEXT_BASE;
        if (offs < 32'(PROG_WORDS * 4)) begin
            return prog[offs[7:2]];
        end
        return addr ^ 32'ha5a55a5a;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // one-cycle synchronous read, output holds while the enable is low
    always @(posedge clk) begin
        if (inst_sram_en) begin
            sram_addr_q <= inst_sram_addr;
        end
        #1;
        inst_sram_rdata = sram_word(sram_addr_q);
    end

    always @(posedge clk) begin
        if (resetn) begin
            cycles <= cycles + 1;
        end
    end

    initial begin
        seed   = 32'h21b7;
        resetn = 1'b0;
        build_program();
        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;
        @(posedge clk);
        while (!done && cycles < 8 * exp_total + 200) begin
            @(posedge clk);
        end
        if (!done) begin
            timeouts++;
            $display("timeout: self-loop not reached after %0d cycles, %0d retires expected",
                     cycles, exp_total);
        end
        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/trace_checker.sv
`timescale 1ns/1ps
`include "mini_la_defines.svh"

module trace_checker (
    input  logic                clk,
    input  logic                resetn,
    input  mini_la_pkg::trace_t trace,
    input  mini_la_pkg::word_t  prog [`MINI_LA_PROG_WORDS],
    output logic                done,
    output int                  errors,
    output int                  exp_total
);

    localparam int MAX_RETIRES = 256;

    mini_la_pkg::word_t    exp_pc    [MAX_RETIRES];
    logic                  exp_we    [MAX_RETIRES];
    mini_la_pkg::reg_idx_t exp_wnum  [MAX_RETIRES];
    mini_la_pkg::word_t    exp_wdata [MAX_RETIRES];
    int                    next_idx;

    // ISA model, walks the image in program order up to the self-loop
    function automatic int build_expected();
        mini_la_pkg::word_t    regs [32];
        mini_la_pkg::word_t    pc;
        mini_la_pkg::word_t    next_pc;
        mini_la_pkg::word_t    pc_offs;
        mini_la_pkg::word_t    inst;
        mini_la_pkg::word_t    wdata;
        mini_la_pkg::word_t    offs;
        mini_la_pkg::word_t    era;
        mini_la_pkg::reg_idx_t rd;
        mini_la_pkg::reg_idx_t rj;
        mini_la_pkg::reg_idx_t rk;
        logic                  we;
        logic                  stop;
        int                    n;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        pc   = `MINI_LA_TEXT_BASE;
        era  = 32'd0;
        n    = 0;
        stop = 1'b0;
        while (!stop && n < MAX_RETIRES) begin
            pc_offs = pc - `MINI_LA_TEXT_BASE;
            if (pc_offs >= 32'(`MINI_LA_PROG_WORDS * 4)) begin
                $display("reference model ran off the program image at pc %h", pc);
                errors++;
                break;
            end
            inst    = prog[pc_offs[7:2]];
            rd      = inst[4:0];
            rj      = inst[9:5];
            rk      = inst[14:10];
            next_pc = pc + 32'd4;
            we      = 1'b0;
            wdata   = 32'd0;
            if (inst == 32'h06483800) begin
                next_pc = era;  // ertn
            end else if (inst[31:24] == 8'h04 && rj == 5'd1
                         && inst[23:10] == `MINI_LA_ERA_CSR) begin
                we    = 1'b1;   // csrwr swaps rd with ERA
                wdata = era;
                era   = regs[rd];
            end else if (inst[31:15] == 17'h00020) begin
                we    = 1'b1;
                wdata = regs[rj] + regs[rk];
            end else if (inst[31:15] == 17'h00022) begin
                we    = 1'b1;
                wdata = regs[rj] - regs[rk];
            end else if (inst[31:15] == 17'h00029) begin
                we    = 1'b1;
                wdata = regs[rj] & regs[rk];
            end else if (inst[31:15] == 17'h0002a) begin
                we    = 1'b1;
                wdata = regs[rj] | regs[rk];
            end else if (inst[31:22] == 10'h00a) begin
                we    = 1'b1;
                wdata = regs[rj] + {{20{inst[21]}}, inst[21:10]};
            end else if (inst[31:25] == 7'h0a) begin
                we    = 1'b1;
                wdata = {inst[24:5], 12'h000};
            end else if (inst[31:26] == 6'h16 || inst[31:26] == 6'h17) begin
                offs = {{14{inst[25]}}, inst[25:10], 2'b00};
                if ((regs[rj] == regs[rd]) == (inst[31:26] == 6'h16)) begin
                    next_pc = pc + offs;
                end
            end else if (inst[31:26] == 6'h14) begin
                offs    = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};
                next_pc = pc + offs;
                stop    = (offs == 32'd0);  // self-loop ends the program
            end
            if (rd == 5'd0) begin
                we = 1'b0;
            end
            exp_pc[n]    = pc;
            exp_we[n]    = we;
            exp_wnum[n]  = rd;
            exp_wdata[n] = wdata;
            if (we) begin
                regs[rd] = wdata;
            end
            n++;
            pc = next_pc;
        end
        return n;
    endfunction

    task automatic compare_retire();
        if (trace.pc !== exp_pc[next_idx]) begin
            $display("MISMATCH at %0t: retire %0d pc %h, expected %h",
                     $time, next_idx, trace.pc, exp_pc[next_idx]);
            errors++;
        end else if (trace.rf_we !== exp_we[next_idx]) begin
            $display("MISMATCH at %0t: pc %h rf_we %b, expected %b",
                     $time, trace.pc, trace.rf_we, exp_we[next_idx]);
            errors++;
        end else if (exp_we[next_idx] && (trace.rf_wnum !== exp_wnum[next_idx]
                     || trace.rf_wdata !== exp_wdata[next_idx])) begin
            $display("MISMATCH at %0t: pc %h wrote r%0d = %h, expected r%0d = %h",
                     $time, trace.pc, trace.rf_wnum, trace.rf_wdata,
                     exp_wnum[next_idx], exp_wdata[next_idx]);
            errors++;
        end
        next_idx++;
        if (next_idx == exp_total) begin
            done = 1'b1;  // later self-loop retires are ignored
        end
    endtask

    initial begin
        done      = 1'b0;
        errors    = 0;
        exp_total = 0;
        next_idx  = 0;
        @(posedge resetn);
        exp_total = build_expected();
        if (exp_total == 0) begin
            $display("reference model produced no retires");
            errors++;
        end
        // trace is a register output, stable at the falling edge
        forever begin
            @(negedge clk);
            if (trace.valid && next_idx < exp_total) begin
                compare_retire();
            end
        end
    end

endmodule

//--- design/mini_la_core.sv
`timescale 1ns/1ps

module mini_la_core (
    input  logic                clk,
    input  logic                resetn,
    output logic                inst_sram_en,
    output mini_la_pkg::word_t  inst_sram_addr,
    input  mini_la_pkg::word_t  inst_sram_rdata,
    output mini_la_pkg::trace_t trace
);

    logic                    id_allowin;
    logic                    exe_allowin;
    logic                    if_to_id_valid;
    logic                    id_to_exe_valid;
    logic                    exe_to_wb_valid;
    logic                    flush;
    mini_la_pkg::word_t      wb_era;     // ertn target back to IF
    mini_la_pkg::br_bus_t    br_bus;
    mini_la_pkg::if_to_id_t  if_to_id;
    mini_la_pkg::id_to_exe_t id_to_exe;
    mini_la_pkg::exe_to_wb_t exe_to_wb;
    mini_la_pkg::dest_info_t exe_dest;
    mini_la_pkg::dest_info_t wb_dest;
    mini_la_pkg::rf_write_t  rf_write;

    if_stage u_if_stage (
        .clk             (clk),
        .resetn          (resetn),
        .inst_sram_en    (inst_sram_en),
        .inst_sram_addr  (inst_sram_addr),
        .inst_sram_rdata (inst_sram_rdata),
        .id_allowin      (id_allowin),
        .br_bus          (br_bus),
        .wb_era          (wb_era),
        .flush           (flush),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id        (if_to_id)
    );

    id_stage u_id_stage (
        .clk             (clk),
        .resetn          (resetn),
        .if_to_id_valid  (if_to_id_valid),
        .if_to_id        (if_to_id),
        .id_allowin      (id_allowin),
        .br_bus          (br_bus),
        .exe_allowin     (exe_allowin),
        .exe_dest        (exe_dest),
        .wb_dest         (wb_dest),
        .rf_write        (rf_write),
        .flush           (flush),
        .id_to_exe_valid (id_to_exe_valid),
        .id_to_exe       (id_to_exe)
    );

    exe_stage u_exe_stage (
        .clk             (clk),
        .resetn          (resetn),
        .id_to_exe_valid (id_to_exe_valid),
        .id_to_exe       (id_to_exe),
        .flush           (flush),
        .exe_allowin     (exe_allowin),
        .exe_dest        (exe_dest),
        .exe_to_wb_valid (exe_to_wb_valid),
        .exe_to_wb       (exe_to_wb)
    );

    wb_stage u_wb_stage (
        .clk             (clk),
        .resetn          (resetn),
        .exe_to_wb_valid (exe_to_wb_valid),
        .exe_to_wb       (exe_to_wb),
        .wb_dest         (wb_dest),
        .rf_write        (rf_write),
        .wb_era          (wb_era),
        .flush           (flush),
        .trace           (trace)
    );

endmodule

//--- design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    exe_to_wb_valid,
    input  mini_la_pkg::exe_to_wb_t exe_to_wb,
    output mini_la_pkg::dest_info_t wb_dest,
    output mini_la_pkg::rf_write_t  rf_write,
    output mini_la_pkg::word_t      wb_era,
    output logic                    flush,
    output mini_la_pkg::trace_t     trace
);

    logic                    wb_valid;
    mini_la_pkg::exe_to_wb_t wb_r;
    mini_la_pkg::word_t      era;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exe_to_wb_valid && !flush;  // nothing younger than ertn retires
        end
    end

    always_ff @(posedge clk) begin
        if (exe_to_wb_valid) begin
            wb_r <= exe_to_wb;
        end
    end

    // csrwr swap, new value comes through the alu as rd + 0
    always_ff @(posedge clk) begin
        if (!resetn) begin
            era <= 32'd0;
        end else if (wb_valid && wb_r.is_csrwr) begin
            era <= wb_r.result;
        end
    end

    assign wb_era = era;
    assign flush  = wb_valid && wb_r.is_ertn;

    assign rf_write.we   = wb_valid && wb_r.rf_we;
    assign rf_write.addr = wb_r.dest;
    assign rf_write.data = wb_r.is_csrwr ? era : wb_r.result;  // csrwr returns old ERA

    assign wb_dest.valid = wb_valid;
    assign wb_dest.rf_we = wb_r.rf_we;
    assign wb_dest.dest  = wb_r.dest;

    // one record per retire
    assign trace.valid    = wb_valid;
    assign trace.pc       = wb_r.pc;
    assign trace.rf_we    = rf_write.we;
    assign trace.rf_wnum  = rf_write.addr;
    assign trace.rf_wdata = rf_write.data;

    // ertn carries no register or ERA write
    assert property (@(posedge clk) disable iff (!resetn)
        flush |-> !wb_r.rf_we && !wb_r.is_csrwr);

endmodule

//--- design/exe_stage.sv
`timescale 1ns/1ps

module exe_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    id_to_exe_valid,
    input  mini_la_pkg::id_to_exe_t id_to_exe,
    input  logic                    flush,
    output logic                    exe_allowin,
    output mini_la_pkg::dest_info_t exe_dest,
    output logic                    exe_to_wb_valid,
    output mini_la_pkg::exe_to_wb_t exe_to_wb
);

    logic                    exe_valid;
    mini_la_pkg::id_to_exe_t exe_r;
    mini_la_pkg::word_t      alu_result;
    logic                    exe_ready_go;
    logic                    wb_allowin;

    assign exe_ready_go    = 1'b1;  // single-cycle alu
    assign wb_allowin      = 1'b1;  // WB never back-pressures
    assign exe_allowin     = !exe_valid || (exe_ready_go && wb_allowin);
    assign exe_to_wb_valid = exe_valid && exe_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            exe_valid <= 1'b0;
        end else if (flush) begin
            exe_valid <= 1'b0;
        end else if (exe_allowin) begin
            exe_valid <= id_to_exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (id_to_exe_valid && exe_allowin) begin
            exe_r <= id_to_exe;
        end
    end

    always_comb begin
        case (exe_r.alu_op)
            mini_la_pkg::ALU_ADD: alu_result = exe_r.src1 + exe_r.src2;
            mini_la_pkg::ALU_SUB: alu_result = exe_r.src1 - exe_r.src2;
            mini_la_pkg::ALU_AND: alu_result = exe_r.src1 & exe_r.src2;
            mini_la_pkg::ALU_OR:  alu_result = exe_r.src1 | exe_r.src2;
            mini_la_pkg::ALU_LUI: alu_result = exe_r.src2;
            default:              alu_result = exe_r.src1 + exe_r.src2;
        endcase
    end

    // seen by ID for the stall check
    assign exe_dest.valid = exe_valid;
    assign exe_dest.rf_we = exe_r.rf_we;
    assign exe_dest.dest  = exe_r.dest;

    assign exe_to_wb.pc       = exe_r.pc;
    assign exe_to_wb.result   = alu_result;
    assign exe_to_wb.dest     = exe_r.dest;
    assign exe_to_wb.rf_we    = exe_r.rf_we;
    assign exe_to_wb.is_csrwr = exe_r.is_csrwr;
    assign exe_to_wb.is_ertn  = exe_r.is_ertn;

    // decode must never mark a write to r0
    assert property (@(posedge clk) disable iff (!resetn)
        exe_valid && exe_r.rf_we |-> exe_r.dest != 5'd0);

endmodule

//--- design/id_stage.sv
`timescale 1ns/1ps
`include "mini_la_defines.svh"

module id_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    if_to_id_valid,
    input  mini_la_pkg::if_to_id_t  if_to_id,
    output logic                    id_allowin,
    output mini_la_pkg::br_bus_t    br_bus,
    input  logic                    exe_allowin,
    input  mini_la_pkg::dest_info_t exe_dest,
    input  mini_la_pkg::dest_info_t wb_dest,
    input  mini_la_pkg::rf_write_t  rf_write,
    input  logic                    flush,
    output logic                    id_to_exe_valid,
    output mini_la_pkg::id_to_exe_t id_to_exe
);

    logic                   id_valid;
    mini_la_pkg::if_to_id_t id_r;
    mini_la_pkg::word_t     inst;
    mini_la_pkg::reg_idx_t  rd;
    mini_la_pkg::reg_idx_t  rj;
    mini_la_pkg::reg_idx_t  rk;
    mini_la_pkg::reg_idx_t  raddr2;
    mini_la_pkg::word_t     rdata1;
    mini_la_pkg::word_t     rdata2;
    mini_la_pkg::word_t     br_offs;
    logic op_add, op_sub, op_and, op_or, op_3r;
    logic op_addi, op_lu12i, op_beq, op_bne, op_b;
    logic op_csrwr, op_ertn;
    logic use_rj, use_r2;
    logic hazard;
    logic id_ready_go;
    logic br_cond;

    // a source is busy while a valid writer ahead of us targets it
    function automatic logic dest_hit(mini_la_pkg::dest_info_t d, mini_la_pkg::reg_idx_t r);
        dest_hit = d.valid && d.rf_we && (d.dest == r) && (r != 5'd0);
    endfunction

    assign inst = id_r.inst;
    assign rd   = inst[4:0];
    assign rj   = inst[9:5];
    assign rk   = inst[14:10];

    assign op_add   = (inst[31:15] == 17'h00020);
    assign op_sub   = (inst[31:15] == 17'h00022);
    assign op_and   = (inst[31:15] == 17'h00029);
    assign op_or    = (inst[31:15] == 17'h0002a);
    assign op_3r    = op_add || op_sub || op_and || op_or;
    assign op_addi  = (inst[31:22] == 10'h00a);
    assign op_lu12i = (inst[31:25] == 7'h0a);
    assign op_beq   = (inst[31:26] == 6'h16);
    assign op_bne   = (inst[31:26] == 6'h17);
    assign op_b     = (inst[31:26] == 6'h14);
    assign op_csrwr = (inst[31:24] == 8'h04) && (rj == 5'd1)
                      && (inst[23:10] == `MINI_LA_ERA_CSR);
    assign op_ertn  = (inst == 32'h06483800);

    // second port reads rd for compares and csrwr, rk otherwise
    assign raddr2 = (op_beq || op_bne || op_csrwr) ? rd : rk;
    assign use_rj = op_3r || op_addi || op_beq || op_bne;
    assign use_r2 = op_3r || op_beq || op_bne || op_csrwr;

    regfile u_regfile (
        .clk      (clk),
        .raddr1   (rj),
        .rdata1   (rdata1),
        .raddr2   (raddr2),
        .rdata2   (rdata2),
        .rf_write (rf_write)
    );

    assign hazard = (use_rj && (dest_hit(exe_dest, rj) || dest_hit(wb_dest, rj)))
                 || (use_r2 && (dest_hit(exe_dest, raddr2) || dest_hit(wb_dest, raddr2)));

    assign id_ready_go     = !hazard;
    assign id_allowin      = !id_valid || (id_ready_go && exe_allowin);
    assign id_to_exe_valid = id_valid && id_ready_go;

    assign br_cond = op_b || (op_beq && (rdata1 == rdata2)) || (op_bne && (rdata1 != rdata2));
    assign br_offs = op_b ? {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00}
                          : {{14{inst[25]}}, inst[25:10], 2'b00};
    assign br_bus.taken  = id_valid && id_ready_go && br_cond;
    assign br_bus.target = id_r.pc + br_offs;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (flush) begin
            id_valid <= 1'b0;
        end else if (id_allowin) begin
            id_valid <= if_to_id_valid && !br_bus.taken;  // squash wrong-path slot
        end
    end

    always_ff @(posedge clk) begin
        if (if_to_id_valid && id_allowin) begin
            id_r <= if_to_id;
        end
    end

    assign id_to_exe.pc     = id_r.pc;
    assign id_to_exe.alu_op = op_sub   ? mini_la_pkg::ALU_SUB :
                              op_and   ? mini_la_pkg::ALU_AND :
                              op_or    ? mini_la_pkg::ALU_OR  :
                              op_lu12i ? mini_la_pkg::ALU_LUI :
                                         mini_la_pkg::ALU_ADD;
    assign id_to_exe.src1   = op_csrwr ? rdata2 : rdata1;  // csrwr moves rd into ERA
    assign id_to_exe.src2   = op_addi  ? {{20{inst[21]}}, inst[21:10]} :
                              op_lu12i ? {inst[24:5], 12'd0} :
                              op_csrwr ? 32'd0 :
                                         rdata2;
    assign id_to_exe.dest     = rd;
    assign id_to_exe.rf_we    = (op_3r || op_addi || op_lu12i || op_csrwr) && (rd != 5'd0);
    assign id_to_exe.is_csrwr = op_csrwr;
    assign id_to_exe.is_ertn  = op_ertn;

    // taken branch must leave ID that edge so the wrong-path slot is squashed
    assert property (@(posedge clk) disable iff (!resetn)
        br_bus.taken |-> id_allowin);

endmodule

//--- design/if_stage.sv
`timescale 1ns/1ps
`include "mini_la_defines.svh"

module if_stage (
    input  logic                   clk,
    input  logic                   resetn,
    output logic                   inst_sram_en,
    output mini_la_pkg::word_t     inst_sram_addr,
    input  mini_la_pkg::word_t     inst_sram_rdata,
    input  logic                   id_allowin,
    input  mini_la_pkg::br_bus_t   br_bus,
    input  mini_la_pkg::word_t     wb_era,
    input  logic                   flush,
    output logic                   if_to_id_valid,
    output mini_la_pkg::if_to_id_t if_to_id
);

    logic               if_valid;
    mini_la_pkg::word_t if_pc;
    mini_la_pkg::word_t seq_pc;
    mini_la_pkg::word_t next_pc;   // pre-IF pc, sent to sram a cycle early
    logic               if_ready_go;
    logic               if_allowin;

    assign if_ready_go    = 1'b1;   // fetch never waits
    assign if_allowin     = !if_valid || (if_ready_go && id_allowin);
    assign if_to_id_valid = if_valid && if_ready_go;

    assign seq_pc = if_pc + 32'd4;

    // ertn target beats a branch in ID, which beats sequential
    assign next_pc = flush        ? wb_era :
                     br_bus.taken ? br_bus.target :
                                    seq_pc;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            if_valid <= 1'b0;
            if_pc    <= `MINI_LA_RESET_PC;
        end else if (if_allowin || flush) begin
            if_valid <= 1'b1;
            if_pc    <= next_pc;
        end
    end

    // sram is read only when the pc moves, so rdata stays put during a stall
    assign inst_sram_en   = resetn && (if_allowin || flush);
    assign inst_sram_addr = next_pc;

    assign if_to_id.inst = inst_sram_rdata;  // already lined up with if_pc
    assign if_to_id.pc   = if_pc;

    // redirect from WB lands in the pc, even under an ID stall
    assert property (@(posedge clk) disable iff (!resetn)
        flush |=> if_valid && (if_pc == $past(wb_era)));

endmodule

//--- design/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                   clk,
    input  mini_la_pkg::reg_idx_t  raddr1,
    output mini_la_pkg::word_t     rdata1,
    input  mini_la_pkg::reg_idx_t  raddr2,
    output mini_la_pkg::word_t     rdata2,
    input  mini_la_pkg::rf_write_t rf_write
);

    mini_la_pkg::word_t rf [31:0];

    always_ff @(posedge clk) begin
        if (rf_write.we && (rf_write.addr != 5'd0)) begin
            rf[rf_write.addr] <= rf_write.data;
        end
    end

    // async reads, r0 hardwired to zero
    assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : rf[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? 32'd0 : rf[raddr2];

endmodule

//--- design/mini_la_pkg.sv
package mini_la_pkg;

    typedef logic [31:0] word_t;     // data or address
    typedef logic [4:0]  reg_idx_t;  // gpr number
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_LUI = 3'd4;  // src2 passes through

    typedef struct packed {
        word_t inst;
        word_t pc;
    } if_to_id_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } br_bus_t;

    typedef struct packed {
        word_t    pc;
        alu_op_t  alu_op;
        word_t    src1;
        word_t    src2;
        reg_idx_t dest;
        logic     rf_we;
        logic     is_csrwr;
        logic     is_ertn;
    } id_to_exe_t;

    typedef struct packed {
        word_t    pc;
        word_t    result;
        reg_idx_t dest;
        logic     rf_we;
        logic     is_csrwr;
        logic     is_ertn;
    } exe_to_wb_t;

    typedef struct packed {
        logic     valid;
        logic     rf_we;
        reg_idx_t dest;
    } dest_info_t;

    typedef struct packed {
        logic     we;
        reg_idx_t addr;
        word_t    data;
    } rf_write_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        logic     rf_we;
        reg_idx_t rf_wnum;
        word_t    rf_wdata;
    } trace_t;

endpackage

//--- include/mini_la_defines.svh
`ifndef MINI_LA_DEFINES_SVH
`define MINI_LA_DEFINES_SVH

// IF pc after reset, first fetch lands on the text base
`define MINI_LA_RESET_PC 32'h1bfffffc

// csr number of ERA
`define MINI_LA_ERA_CSR 14'h0006

// instruction image placement
`define MINI_LA_TEXT_BASE 32'h1c000000

// program length in words
`define MINI_LA_PROG_WORDS 64

`endif
